/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tulip_dsp_tb
FILE_LIST := files.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard verilog/*.sv verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# pass only when the testbench prints its pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)

/* files.f */
verilog/tulip_pkg.sv
verilog/gain_stage.sv
verilog/transfer_lut.sv
verilog/tulip_dsp.sv
verif/tb_clock_gen.sv
verif/tulip_dsp_tb.sv

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // reset released on a rising edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

/* verif/tulip_dsp_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tulip_dsp_tb;

  import tulip_pkg::*;

  localparam int LUT_DEPTH = 2**C_LUT_ADDR_WIDTH;
  localparam int GAIN_FRAC = 16;
  localparam logic [C_GAIN_WIDTH-1:0] UNITY = 32'h0001_0000;
  localparam longint S_MAX = 2**(C_ADC_DWIDTH-1) - 1;
  localparam longint S_MIN = -(2**(C_ADC_DWIDTH-1));
  // 1024 writes plus about 3000 samples at half rate, with margin
  localparam int MAX_CYCLES = 20_000;

  logic                    clk;
  logic                    rst;
  logic                    bypass;
  logic                    bypass_lut_tf;
  logic [C_GAIN_WIDTH-1:0] input_gain;
  logic [C_GAIN_WIDTH-1:0] output_gain;
  lut_entry_t              lut_prog_din;
  logic                    lut_prog_din_valid;
  logic                    lut_prog_din_ready;
  logic                    lut_prog_din_done;
  sample_t                 din;
  logic                    din_valid;
  logic                    din_ready;
  sample_t                 dout;
  logic                    dout_valid;
  logic                    dout_ready;

  lut_entry_t lut_model [LUT_DEPTH];
  sample_t    exp_q [$];
  sample_t    expected;
  string      test_name;
  int         data_errors;
  int         protocol_errors;
  int         prog_count;
  int         cycle_count;
  logic       held_valid;
  sample_t    held_data;

  tb_clock_gen #(.PERIOD(10), .RESET_CYCLES(2)) u_clock_gen (.clk(clk), .rst(rst));

  tulip_dsp dut (
    .clk                (clk),
    .rst                (rst),
    .bypass             (bypass),
    .bypass_lut_tf      (bypass_lut_tf),
    .input_gain         (input_gain),
    .output_gain        (output_gain),
    .lut_prog_din       (lut_prog_din),
    .lut_prog_din_valid (lut_prog_din_valid),
    .lut_prog_din_ready (lut_prog_din_ready),
    .lut_prog_din_done  (lut_prog_din_done),
    .din                (din),
    .din_valid          (din_valid),
    .din_ready          (din_ready),
    .dout               (dout),
    .dout_valid         (dout_valid),
    .dout_ready         (dout_ready)
  );

  // floor of sample times gain, clamped to the sample range
  function automatic sample_t apply_gain(sample_t s, logic [C_GAIN_WIDTH-1:0] g);
    longint p;
    p = longint'(s) * longint'({32'd0, g});
    p = p >>> GAIN_FRAC;
    if (p > S_MAX) begin
      p = S_MAX;
    end else if (p < S_MIN) begin
      p = S_MIN;
    end
    return p[C_ADC_DWIDTH-1:0];
  endfunction

  function automatic sample_t interpolate(sample_t s);
    int     idx;
    int     frac;
    int     a;
    int     b;
    longint ea;
    longint eb;
    longint r;
    idx  = int'(s[C_ADC_DWIDTH-1 -: C_LUT_ADDR_WIDTH]);
    frac = int'(s[C_LUT_FRAC_WIDTH-1:0]);
    // most negative input lands on address 0
    a  = idx ^ (LUT_DEPTH / 2);
    b  = (a == LUT_DEPTH - 1) ? a : a + 1;
    ea = lut_model[a];
    eb = lut_model[b];
    r  = ea + (((eb - ea) * frac) >>> C_LUT_FRAC_WIDTH);
    return r[C_ADC_DWIDTH-1:0];
  endfunction

  function automatic sample_t chain_output(sample_t s, logic [C_GAIN_WIDTH-1:0] g_in,
                                           logic [C_GAIN_WIDTH-1:0] g_out, logic lut_off);
    sample_t v;
    v = apply_gain(s, g_in);
    if (!lut_off) begin
      v = interpolate(v);
    end
    return apply_gain(v, g_out);
  endfunction

  function automatic sample_t random_sample(int last_pct);
    logic [31:0] r;
    sample_t     s;
    r = $urandom;
    s = r[C_ADC_DWIDTH-1:0];
    if ($urandom_range(0, 99) < last_pct) begin
      s[C_ADC_DWIDTH-1 -: C_LUT_ADDR_WIDTH] = 10'h1FF;
    end
    return s;
  endfunction

  function automatic logic [C_GAIN_WIDTH-1:0] random_gain(int max_whole);
    return $urandom_range(0, max_whole << GAIN_FRAC);
  endfunction

  task automatic program_table();
    int ptr;
    ptr = 0;
    while (ptr < LUT_DEPTH) begin
      @(posedge clk);
      if (lut_prog_din_valid && lut_prog_din_ready) begin
        ptr++;
      end
      if (ptr < LUT_DEPTH) begin
        lut_prog_din_valid <= ($urandom_range(0, 3) != 0);
        lut_prog_din       <= lut_model[ptr];
      end else begin
        // keep offering words, the loader must refuse them
        lut_prog_din_valid <= 1'b1;
        lut_prog_din       <= '0;
      end
    end
    repeat (4) @(posedge clk);
    lut_prog_din_valid <= 1'b0;
  endtask

  task automatic set_config(logic [C_GAIN_WIDTH-1:0] g_in, logic [C_GAIN_WIDTH-1:0] g_out,
                            logic lut_off, logic global_off);
    @(posedge clk);
    input_gain    <= g_in;
    output_gain   <= g_out;
    bypass_lut_tf <= lut_off;
    bypass        <= global_off;
  endtask

  task automatic run_stream(int n, int valid_pct, int ready_pct, int last_pct);
    int sent;
    sent = 0;
    while (sent < n) begin
      @(posedge clk);
      if (din_valid && din_ready) begin
        sent++;
      end
      dout_ready <= ($urandom_range(0, 99) < ready_pct);
      // a stalled sample stays put
      if (!din_valid || din_ready) begin
        if (sent < n && $urandom_range(0, 99) < valid_pct) begin
          din_valid <= 1'b1;
          din       <= random_sample(last_pct);
        end else begin
          din_valid <= 1'b0;
        end
      end
    end
  endtask

  task automatic wait_drain();
    @(posedge clk);
    dout_ready <= 1'b1;
    @(negedge clk);
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      held_valid = 1'b0;
    end else begin
      if (prog_count < LUT_DEPTH) begin
        if (!lut_prog_din_ready || lut_prog_din_done) begin
          $display("%s: loader closed after only %0d words", test_name, prog_count);
          protocol_errors++;
        end
      end else if (lut_prog_din_ready || !lut_prog_din_done) begin
        $display("%s: loader still open after %0d words", test_name, prog_count);
        protocol_errors++;
      end
      if (lut_prog_din_valid && lut_prog_din_ready) begin
        prog_count++;
      end

      if (bypass) begin
        held_valid = 1'b0;
        if (dout !== din) begin
          $display("[ERROR] %s: expected %h, got %h", test_name, din, dout);
          data_errors++;
        end
        if (dout_valid !== din_valid || din_ready !== dout_ready) begin
          $display("%s: bypass does not pass valid and ready straight through", test_name);
          protocol_errors++;
        end
      end else begin
        if (held_valid && (!dout_valid || dout !== held_data)) begin
          $display("%s: output changed while it was stalled", test_name);
          protocol_errors++;
        end
        held_valid = dout_valid && !dout_ready;
        held_data  = dout;
        if (din_valid && din_ready) begin
          exp_q.push_back(chain_output(din, input_gain, output_gain, bypass_lut_tf));
        end
        if (dout_valid && dout_ready) begin
          if (exp_q.size() == 0) begin
            $display("%s: output sample with nothing pending", test_name);
            protocol_errors++;
          end else begin
            expected = exp_q.pop_front();
            if (dout !== expected) begin
              $display("[ERROR] %s: expected %h, got %h", test_name, expected, dout);
              data_errors++;
            end
          end
        end
      end
    end

    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run not finished after %0d cycles, stuck in %s", MAX_CYCLES, test_name);
      $display("errors: %0d data, %0d protocol", data_errors, protocol_errors);
      $display("test failed");
      $finish;
    end
  end

  initial begin
    int          i;
    int          blk;
    logic [31:0] r;
    void'($urandom(75));
    bypass             = 1'b0;
    bypass_lut_tf      = 1'b1;
    input_gain         = UNITY;
    output_gain        = UNITY;
    lut_prog_din       = '0;
    lut_prog_din_valid = 1'b0;
    din                = '0;
    din_valid          = 1'b0;
    dout_ready         = 1'b1;
    data_errors        = 0;
    protocol_errors    = 0;
    prog_count         = 0;
    cycle_count        = 0;
    test_name          = "reset";
    for (i = 0; i < LUT_DEPTH; i++) begin
      r = $urandom;
      lut_model[i] = r[C_ADC_DWIDTH-1:0];
    end

    @(posedge clk);
    while (rst) begin
      @(posedge clk);
    end

    test_name = "programming";
    program_table();

    test_name = "identity";
    set_config(UNITY, UNITY, 1'b1, 1'b0);
    run_stream(300, 80, 100, 0);
    wait_drain();

    test_name = "gain";
    for (blk = 0; blk < 6; blk++) begin
      set_config(random_gain(4), random_gain(4), 1'b1, 1'b0);
      run_stream(100, 90, 90, 0);
      wait_drain();
    end

    // some samples pinned to the last table index
    test_name = "interpolation";
    set_config(UNITY, UNITY, 1'b0, 1'b0);
    run_stream(800, 80, 100, 15);
    wait_drain();

    test_name = "backpressure";
    set_config(random_gain(2), random_gain(2), 1'b0, 1'b0);
    run_stream(1000, 50, 50, 10);
    wait_drain();

    test_name = "global_bypass";
    set_config(UNITY, UNITY, 1'b0, 1'b1);
    run_stream(200, 60, 60, 0);
    wait_drain();
    set_config(UNITY, UNITY, 1'b0, 1'b0);
    wait_drain();

    if (prog_count != LUT_DEPTH) begin
      $display("table took %0d words instead of %0d", prog_count, LUT_DEPTH);
      protocol_errors++;
    end

    $display("errors: %0d data, %0d protocol", data_errors, protocol_errors);
    if (data_errors + protocol_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/gain_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module gain_stage #(
  parameter int G_INTEGER_BITS = 16,
  parameter int G_DECIMAL_BITS = 16
) (
  input  logic                              clk,
  input  logic                              rst,

  input  logic [tulip_pkg::C_GAIN_WIDTH-1:0] gain,

  input  tulip_pkg::sample_t                din,
  input  logic                              din_valid,
  output logic                              din_ready,

  output tulip_pkg::sample_t                dout,
  output logic                              dout_valid,
  input  logic                              dout_ready
);

  import tulip_pkg::*;

  // signed sample times zero-extended gain
  localparam int PROD_W  = C_ADC_DWIDTH + C_GAIN_WIDTH + 1;
  // bits left once the fraction is dropped
  localparam int SHIFT_W = C_ADC_DWIDTH + G_INTEGER_BITS + 1;

  logic signed [C_GAIN_WIDTH:0]       gain_s;
  logic signed [PROD_W-1:0]           product;
  logic signed [SHIFT_W-1:0]          shifted;
  logic [SHIFT_W-C_ADC_DWIDTH:0]      upper;
  sample_t                            sat;

  if (G_INTEGER_BITS + G_DECIMAL_BITS != C_GAIN_WIDTH) begin : g_bad_split
    $error("gain_stage: integer and decimal bits must add up to the gain width");
  end

  assign gain_s  = {1'b0, gain};
  assign product = din * gain_s;

  // dropping the low bits floors toward minus infinity
  assign shifted = product[G_DECIMAL_BITS +: SHIFT_W];
  assign upper   = shifted[SHIFT_W-1:C_ADC_DWIDTH-1];

  always_comb begin
    if (&upper || ~|upper) begin
      sat = shifted[C_ADC_DWIDTH-1:0];
    end else if (shifted[SHIFT_W-1]) begin
      sat = {1'b1, {(C_ADC_DWIDTH-1){1'b0}}};
    end else begin
      sat = {1'b0, {(C_ADC_DWIDTH-1){1'b1}}};
    end
  end

  // take a new sample when the register is empty or draining
  assign din_ready = ~dout_valid | dout_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      dout_valid <= 1'b0;
    end else if (din_ready) begin
      dout_valid <= din_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (din_valid && din_ready) begin
      dout <= sat;
    end
  end

  a_dout_hold: assert property (@(posedge clk) disable iff (rst)
    dout_valid && !dout_ready |=> dout_valid && $stable(dout));

endmodule

`default_nettype wire

/* verilog/transfer_lut.sv */
`timescale 1ns/1ps
`default_nettype none

module transfer_lut (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  bypass,

  input  tulip_pkg::lut_entry_t lut_prog_din,
  input  logic                  lut_prog_din_valid,
  output logic                  lut_prog_din_ready,
  output logic                  lut_prog_din_done,

  input  tulip_pkg::sample_t    din,
  input  logic                  din_valid,
  output logic                  din_ready,

  output tulip_pkg::sample_t    dout,
  output logic                  dout_valid,
  input  logic                  dout_ready
);

  import tulip_pkg::*;

  localparam int LUT_DEPTH = 2**C_LUT_ADDR_WIDTH;

  lut_entry_t                    lut_mem [LUT_DEPTH];
  logic [C_LUT_ADDR_WIDTH-1:0]   wr_addr;

  sample_word_u                  din_word;
  logic [C_LUT_ADDR_WIDTH-1:0]   addr_a;
  logic [C_LUT_ADDR_WIDTH-1:0]   addr_b;
  lut_entry_t                    rd_a;
  lut_entry_t                    rd_b;

  logic                          s1_valid;
  logic                          s1_ready;
  lut_entry_t                    s1_entry_a;
  lut_entry_t                    s1_entry_b;
  logic [C_LUT_FRAC_WIDTH-1:0]   s1_frac;
  sample_t                       s1_raw;
  logic                          s1_bypass;

  logic                          s2_ready;
  logic signed [C_ADC_DWIDTH:0]       diff;
  logic signed [C_LUT_FRAC_WIDTH:0]   frac_s;
  logic signed [C_ADC_DWIDTH+C_LUT_FRAC_WIDTH+1:0] prod;
  logic signed [C_ADC_DWIDTH+1:0]     step;
  logic signed [C_ADC_DWIDTH+1:0]     interp;

  // loader, words arrive in address order
  assign lut_prog_din_ready = ~lut_prog_din_done;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_addr           <= '0;
      lut_prog_din_done <= 1'b0;
    end else if (lut_prog_din_valid && lut_prog_din_ready) begin
      wr_addr <= wr_addr + 1'b1;
      if (wr_addr == '1) begin
        lut_prog_din_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lut_prog_din_valid && lut_prog_din_ready) begin
      lut_mem[wr_addr] <= lut_prog_din;
    end
  end

  // offset binary address, top index bit flipped
  assign din_word.sample = din;
  assign addr_a = {~din_word.lut_pos.index[C_LUT_ADDR_WIDTH-1],
                   din_word.lut_pos.index[C_LUT_ADDR_WIDTH-2:0]};
  assign addr_b = (addr_a == '1) ? addr_a : addr_a + 1'b1;

  // entries not yet written since reset read as zero
  assign rd_a = (lut_prog_din_done || addr_a < wr_addr) ? lut_mem[addr_a] : '0;
  assign rd_b = (lut_prog_din_done || addr_b < wr_addr) ? lut_mem[addr_b] : '0;

  assign s2_ready  = ~dout_valid | dout_ready;
  assign s1_ready  = ~s1_valid | s2_ready;
  assign din_ready = s1_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else if (s1_ready) begin
      s1_valid <= din_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (din_valid && s1_ready) begin
      s1_entry_a <= rd_a;
      s1_entry_b <= rd_b;
      s1_frac    <= din_word.lut_pos.frac;
      s1_raw     <= din;
      s1_bypass  <= bypass;
    end
  end

  // step lies between zero and diff, so the sum fits a sample
  assign diff   = s1_entry_b - s1_entry_a;
  assign frac_s = {1'b0, s1_frac};
  assign prod   = diff * frac_s;
  assign step   = prod[C_LUT_FRAC_WIDTH +: C_ADC_DWIDTH+2];
  assign interp = s1_entry_a + step;

  always_ff @(posedge clk) begin
    if (rst) begin
      dout_valid <= 1'b0;
    end else if (s2_ready) begin
      dout_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid && s2_ready) begin
      dout <= s1_bypass ? s1_raw : interp[C_ADC_DWIDTH-1:0];
    end
  end

  a_dout_hold: assert property (@(posedge clk) disable iff (rst)
    dout_valid && !dout_ready |=> dout_valid && $stable(dout));

  a_done_sticky: assert property (@(posedge clk)
    lut_prog_din_done && !rst |=> lut_prog_din_done);

endmodule

`default_nettype wire

/* verilog/tulip_dsp.sv */
`timescale 1ns/1ps
`default_nettype none

module tulip_dsp (
  input  logic                              clk,
  input  logic                              rst,

  input  logic                              bypass,
  input  logic                              bypass_lut_tf,

  input  logic [tulip_pkg::C_GAIN_WIDTH-1:0] input_gain,
  input  logic [tulip_pkg::C_GAIN_WIDTH-1:0] output_gain,

  input  tulip_pkg::lut_entry_t             lut_prog_din,
  input  logic                              lut_prog_din_valid,
  output logic                              lut_prog_din_ready,
  output logic                              lut_prog_din_done,

  input  tulip_pkg::sample_t                din,
  input  logic                              din_valid,
  output logic                              din_ready,

  output tulip_pkg::sample_t                dout,
  output logic                              dout_valid,
  input  logic                              dout_ready
);

  import tulip_pkg::*;

  logic     gain0_din_valid;
  logic     gain0_din_ready;
  sample_t  gain0_dout;
  logic     gain0_dout_valid;
  logic     gain0_dout_ready;

  sample_t  lut_dout;
  logic     lut_dout_valid;
  logic     lut_dout_ready;

  sample_t  gain1_dout;
  logic     gain1_dout_valid;
  logic     gain1_dout_ready;

  // chain frozen while bypassed
  assign gain0_din_valid  = din_valid & ~bypass;
  assign gain1_dout_ready = dout_ready & ~bypass;

  gain_stage #(
    .G_INTEGER_BITS (16),
    .G_DECIMAL_BITS (16)
  ) u_input_gain (
    .clk        (clk),
    .rst        (rst),
    .gain       (input_gain),
    .din        (din),
    .din_valid  (gain0_din_valid),
    .din_ready  (gain0_din_ready),
    .dout       (gain0_dout),
    .dout_valid (gain0_dout_valid),
    .dout_ready (gain0_dout_ready)
  );

  transfer_lut u_transfer_lut (
    .clk                (clk),
    .rst                (rst),
    .bypass             (bypass_lut_tf),
    .lut_prog_din       (lut_prog_din),
    .lut_prog_din_valid (lut_prog_din_valid),
    .lut_prog_din_ready (lut_prog_din_ready),
    .lut_prog_din_done  (lut_prog_din_done),
    .din                (gain0_dout),
    .din_valid          (gain0_dout_valid),
    .din_ready          (gain0_dout_ready),
    .dout               (lut_dout),
    .dout_valid         (lut_dout_valid),
    .dout_ready         (lut_dout_ready)
  );

  gain_stage #(
    .G_INTEGER_BITS (16),
    .G_DECIMAL_BITS (16)
  ) u_output_gain (
    .clk        (clk),
    .rst        (rst),
    .gain       (output_gain),
    .din        (lut_dout),
    .din_valid  (lut_dout_valid),
    .din_ready  (lut_dout_ready),
    .dout       (gain1_dout),
    .dout_valid (gain1_dout_valid),
    .dout_ready (gain1_dout_ready)
  );

  // global bypass is purely combinational
  assign dout       = bypass ? din : gain1_dout;
  assign dout_valid = bypass ? din_valid : gain1_dout_valid;
  assign din_ready  = bypass ? dout_ready : gain0_din_ready;

endmodule

`default_nettype wire

/* verilog/tulip_pkg.sv */
`default_nettype none

package tulip_pkg;

  localparam int C_ADC_DWIDTH = 24;

  // gain word, unsigned fixed point
  localparam int C_GAIN_WIDTH = 32;

  localparam int C_LUT_ADDR_WIDTH = 10;
  localparam int C_LUT_FRAC_WIDTH = C_ADC_DWIDTH - C_LUT_ADDR_WIDTH;

  typedef logic signed [C_ADC_DWIDTH-1:0] sample_t;

  typedef logic signed [C_ADC_DWIDTH-1:0] lut_entry_t;

  // table position of a sample, index on top
  typedef struct packed {
    logic [C_LUT_ADDR_WIDTH-1:0] index;
    logic [C_LUT_FRAC_WIDTH-1:0] frac;
  } lut_pos_t;

  typedef union packed {
    sample_t  sample;
    lut_pos_t lut_pos;
  } sample_word_u;

endpackage

`default_nettype wire
